/* design/motion_pkg.sv */
package motion_pkg;

	// Signed absolute coordinate width.
	localparam int COORD_BITS = 12;

	// One extra bit so any difference of two coordinates fits.
	localparam int DELTA_BITS = COORD_BITS + 1;

	// Moves buffered between planner and stepper.
	localparam int FIFO_DEPTH = 4;

	// Clocks per step-rate tick.
	localparam int STEP_DIV = 3;

	// Absolute target point from the host.
	typedef struct packed {
		logic signed [COORD_BITS-1:0] x;
		logic signed [COORD_BITS-1:0] y;
	} point_t;

	// Relative move, one signed delta per axis.
	typedef struct packed {
		logic signed [DELTA_BITS-1:0] dx;
		logic signed [DELTA_BITS-1:0] dy;
	} move_t;

endpackage : motion_pkg

/* design/move_fifo.sv */
module move_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 4
) (
	input  logic clk,
	input  logic reset,
	input  T     in_data,
	input  logic in_valid,
	output logic in_ready,
	output T     out_data,
	output logic out_valid,
	input  logic out_ready
);

	T                           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       full;
	logic                       empty;
	logic                       wr_en;
	logic                       rd_en;

	assign full  = (count == ($clog2(DEPTH+1))'(DEPTH));
	assign empty = (count == '0);

	assign in_ready  = !full || out_ready; // A full FIFO takes a write while it is read.
	assign out_valid = !empty;
	assign out_data  = mem[rd_ptr]; // Head entry.

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	// Payload storage.
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else begin
			if (wr_en) begin
				// Wrap for any depth, not only powers of two.
				if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				if (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Idle or both sides move.
			endcase
		end
	end

endmodule : move_fifo

/* design/move_planner.sv */
module move_planner (
	input  logic                clk,
	input  logic                reset,
	input  motion_pkg::point_t  target,
	input  logic                target_valid,
	output logic                target_ready,
	output motion_pkg::move_t   plan_move,
	output logic                plan_valid,
	input  logic                plan_ready
);

	motion_pkg::point_t pos; // Commanded position.
	logic               accept;
	logic               drain;
	motion_pkg::move_t  next_move;

	// Sign extend both operands before subtracting.
	function automatic logic signed [motion_pkg::DELTA_BITS-1:0] delta(
		input logic signed [motion_pkg::COORD_BITS-1:0] to,
		input logic signed [motion_pkg::COORD_BITS-1:0] from
	);
		logic signed [motion_pkg::DELTA_BITS-1:0] to_ext;
		logic signed [motion_pkg::DELTA_BITS-1:0] from_ext;
		to_ext   = {to[motion_pkg::COORD_BITS-1], to};
		from_ext = {from[motion_pkg::COORD_BITS-1], from};
		return to_ext - from_ext;
	endfunction

	assign drain        = plan_valid && plan_ready;
	assign target_ready = !plan_valid || plan_ready; // Stage empty or emptying.
	assign accept       = target_valid && target_ready;

	assign next_move.dx = delta(target.x, pos.x);
	assign next_move.dy = delta(target.y, pos.y);

	// Output stage payload.
	always_ff @(posedge clk) begin
		if (accept) begin
			plan_move <= next_move;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos        <= '0;
			plan_valid <= 1'b0;
		end
		else begin
			if (accept) begin
				pos        <= target;
				plan_valid <= 1'b1;
			end
			else if (drain) begin
				plan_valid <= 1'b0;
			end
		end
	end

endmodule : move_planner

/* design/step_rate_gen.sv */
module step_rate_gen (
	input  logic clk,
	input  logic reset,
	output logic step_en
);

	logic [$clog2(motion_pkg::STEP_DIV)-1:0] div_cnt;
	logic                                    wrap;

	// Last count of the period.
	assign wrap = (div_cnt == $clog2(motion_pkg::STEP_DIV)'(motion_pkg::STEP_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end
		else if (wrap) begin
			div_cnt <= '0;
		end
		else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign step_en = wrap; // One clock per STEP_DIV clocks.

endmodule : step_rate_gen

/* design/xy_motion_top.sv */
module xy_motion_top (
	input  logic               clk,
	input  logic               reset,
	input  motion_pkg::point_t target,
	input  logic               target_valid,
	output logic               target_ready,
	output logic               step_x,
	output logic               dir_x,
	output logic               step_y,
	output logic               dir_y,
	output logic               idle
);

	motion_pkg::move_t plan_move;
	logic              plan_valid;
	logic              plan_ready;
	motion_pkg::move_t fifo_move;
	logic              fifo_valid;
	logic              fifo_ready;
	logic              step_en;
	logic              busy;

	step_rate_gen u_rate (
		.clk     (clk),
		.reset   (reset),
		.step_en (step_en)
	);

	move_planner u_planner (
		.clk          (clk),
		.reset        (reset),
		.target       (target),
		.target_valid (target_valid),
		.target_ready (target_ready),
		.plan_move    (plan_move),
		.plan_valid   (plan_valid),
		.plan_ready   (plan_ready)
	);

	move_fifo #(
		.T     (motion_pkg::move_t),
		.DEPTH (motion_pkg::FIFO_DEPTH)
	) u_fifo (
		.clk       (clk),
		.reset     (reset),
		.in_data   (plan_move),
		.in_valid  (plan_valid),
		.in_ready  (plan_ready),
		.out_data  (fifo_move),
		.out_valid (fifo_valid),
		.out_ready (fifo_ready)
	);

	xy_stepper u_stepper (
		.clk        (clk),
		.reset      (reset),
		.step_en    (step_en),
		.move       (fifo_move),
		.move_valid (fifo_valid),
		.move_ready (fifo_ready),
		.step_x     (step_x),
		.dir_x      (dir_x),
		.step_y     (step_y),
		.dir_y      (dir_y),
		.busy       (busy)
	);

	// Nothing planned, nothing queued, nothing stepping.
	assign idle = !plan_valid && !fifo_valid && !busy;

endmodule : xy_motion_top

/* design/xy_stepper.sv */
module xy_stepper (
	input  logic              clk,
	input  logic              reset,
	input  logic              step_en,
	input  motion_pkg::move_t move,
	input  logic              move_valid,
	output logic              move_ready,
	output logic              step_x,
	output logic              dir_x,
	output logic              step_y,
	output logic              dir_y,
	output logic              busy
);

	logic [motion_pkg::DELTA_BITS-2:0] cnt_x; // Steps left on x.
	logic [motion_pkg::DELTA_BITS-2:0] cnt_y;
	logic [motion_pkg::DELTA_BITS-2:0] mag_x;
	logic [motion_pkg::DELTA_BITS-2:0] mag_y;
	logic                              phase; // High half of the step period.
	logic                              accept;
	logic                              zero_x;
	logic                              zero_y;
	logic                              last_x;
	logic                              last_y;

	// Magnitude of a signed delta.
	function automatic logic [motion_pkg::DELTA_BITS-2:0] magnitude(
		input logic signed [motion_pkg::DELTA_BITS-1:0] d
	);
		logic [motion_pkg::DELTA_BITS-1:0] neg;
		neg = -d;
		if (d[motion_pkg::DELTA_BITS-1])
			return neg[motion_pkg::DELTA_BITS-2:0];
		else
			return d[motion_pkg::DELTA_BITS-2:0];
	endfunction

	assign mag_x = magnitude(move.dx);
	assign mag_y = magnitude(move.dy);

	assign move_ready = !busy && step_en;
	assign accept     = move_valid && move_ready;

	assign zero_x = (cnt_x == '0);
	assign zero_y = (cnt_y == '0);
	assign last_x = (cnt_x <= (motion_pkg::DELTA_BITS-1)'(1));
	assign last_y = (cnt_y <= (motion_pkg::DELTA_BITS-1)'(1));

	// A spent axis stays low.
	assign step_x = phase && !zero_x;
	assign step_y = phase && !zero_y;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			phase <= 1'b0;
			cnt_x <= '0;
			cnt_y <= '0;
			dir_x <= 1'b0;
			dir_y <= 1'b0;
		end
		else if (step_en) begin
			if (accept) begin
				busy  <= 1'b1;
				phase <= 1'b0;
				cnt_x <= mag_x;
				cnt_y <= mag_y;
				dir_x <= !move.dx[motion_pkg::DELTA_BITS-1]; // High is positive.
				dir_y <= !move.dy[motion_pkg::DELTA_BITS-1];
			end
			else if (busy) begin
				if (zero_x && zero_y) begin
					busy <= 1'b0; // Zero move ends on the next tick.
				end
				else begin
					phase <= !phase;
					// Falling phase spends one step per active axis.
					if (phase) begin
						if (!zero_x)
							cnt_x <= cnt_x - 1'b1;
						if (!zero_y)
							cnt_y <= cnt_y - 1'b1;
						if (last_x && last_y)
							busy <= 1'b0;
					end
				end
			end
		end
	end

endmodule : xy_stepper

/* verif/xy_motion_stimulus.txt */
// First word is the point count. Then one point per line: x y gap, coordinates as
// 12-bit two's complement hex, gap in idle cycles before the offer (00 gives a random delay).
10
014 000 03
014 00f 00
014 00f 02
ff6 ffb 00
005 fe7 04
005 fe7 00
fe2 00a 01
000 000 05
// Burst of long moves that fills the planner stage and the FIFO.
028 028 00
fd8 028 00
fd8 fd8 00
028 fd8 00
028 028 00
000 000 00
032 fd3 00
fff 001 00

/* verif/xy_motion_tb.sv */
module xy_motion_tb;

	localparam int MAX_POINTS = 32;
	localparam int CLK_PERIOD = 40;

	logic               clk;
	logic               reset;
	motion_pkg::point_t target;
	logic               target_valid;
	logic               target_ready;
	logic               step_x;
	logic               dir_x;
	logic               step_y;
	logic               dir_y;
	logic               idle;

	logic [15:0]        stim [1 + 3*MAX_POINTS]; // Count, then x, y, gap per point.
	motion_pkg::point_t points [MAX_POINTS];
	int                 gaps [MAX_POINTS];
	int                 num_points;
	motion_pkg::move_t  exp_moves [$]; // Nonzero moves still to be stepped.
	motion_pkg::move_t  seg_exp;
	motion_pkg::point_t last_target = '0;
	logic [31:0]        lcg_state = 32'hec2646e7;
	logic               prev_step_x = 1'b0;
	logic               prev_step_y = 1'b0;
	logic               prev_dir_x = 1'b0;
	logic               prev_dir_y = 1'b0;
	logic               seg_open = 1'b0;
	logic               saw_stall = 1'b0;
	logic               wd_armed = 1'b0;
	int                 wd_limit;
	int                 cyc = 0;
	int                 last_rise = 0;
	int                 seg_dx;
	int                 seg_dy;
	int                 seg_idx = 0;
	int                 model_x = 0;
	int                 model_y = 0;
	int                 acc_total = 0;
	int                 acc_at_open;
	int                 value_errors = 0;
	int                 other_errors = 0;

	xy_motion_top DUT (
		.clk          (clk),
		.reset        (reset),
		.target       (target),
		.target_valid (target_valid),
		.target_ready (target_ready),
		.step_x       (step_x),
		.dir_x        (dir_x),
		.step_y       (step_y),
		.dir_y        (dir_y),
		.idle         (idle)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = !clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int abs_int(input int v);
		return (v < 0) ? -v : v;
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: expected %b, actual %b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_point(input string name, input motion_pkg::point_t exp,
			input motion_pkg::point_t act);
		if (act !== exp) begin
			$display("** Error %s: expected (%0d,%0d), actual (%0d,%0d)", name,
				$signed(exp.x), $signed(exp.y), $signed(act.x), $signed(act.y));
			value_errors++;
		end
	endtask

	task automatic check_move(input string name, input motion_pkg::move_t exp,
			input motion_pkg::move_t act);
		if (act !== exp) begin
			$display("** Error %s: expected (%0d,%0d), actual (%0d,%0d)", name,
				$signed(exp.dx), $signed(exp.dy), $signed(act.dx), $signed(act.dy));
			value_errors++;
		end
	endtask

	task automatic check_reset_state(input string name);
		check_bit({name, "_step_x"}, 1'b0, step_x);
		check_bit({name, "_step_y"}, 1'b0, step_y);
		check_bit({name, "_idle"}, 1'b1, idle);
		check_bit({name, "_target_ready"}, 1'b1, target_ready);
	endtask

	task automatic open_segment();
		if (exp_moves.size() == 0) begin
			$display("Error: step pulses seen with no move pending");
			other_errors++;
			seg_exp = '0;
		end
		else begin
			seg_exp = exp_moves.pop_front();
		end
		seg_dx      = 0;
		seg_dy      = 0;
		acc_at_open = acc_total;
		seg_open    = 1'b1;
	endtask

	task automatic close_segment();
		motion_pkg::move_t act;
		act.dx = (motion_pkg::DELTA_BITS)'(seg_dx);
		act.dy = (motion_pkg::DELTA_BITS)'(seg_dy);
		check_move($sformatf("move_%0d", seg_idx), seg_exp, act);
		// Stepper holds one, FIFO and planner stage hold the rest.
		check_bit($sformatf("move_%0d_accept_bound", seg_idx), 1'b1,
			(acc_total - acc_at_open) <= motion_pkg::FIFO_DEPTH + 2);
		seg_open = 1'b0;
		seg_idx++;
	endtask

	// Step monitor, sampled mid-cycle where outputs are settled.
	always @(negedge clk) begin : step_monitor
		logic rise_x;
		logic rise_y;
		cyc++;
		rise_x = step_x && !prev_step_x;
		rise_y = step_y && !prev_step_y;
		if (rise_x || rise_y) begin
			// Steps inside a move come every two ticks.
			if (seg_open && (cyc - last_rise > 2 * motion_pkg::STEP_DIV))
				close_segment();
			if (!seg_open)
				open_segment();
			last_rise = cyc;
		end
		if (rise_x) begin
			check_bit($sformatf("move_%0d_dir_x", seg_idx), $signed(seg_exp.dx) > 0, dir_x);
			seg_dx  += dir_x ? 1 : -1;
			model_x += dir_x ? 1 : -1;
		end
		if (rise_y) begin
			check_bit($sformatf("move_%0d_dir_y", seg_idx), $signed(seg_exp.dy) > 0, dir_y);
			seg_dy  += dir_y ? 1 : -1;
			model_y += dir_y ? 1 : -1;
		end
		if (step_x && prev_step_x)
			check_bit("dir_x_hold", prev_dir_x, dir_x);
		if (step_y && prev_step_y)
			check_bit("dir_y_hold", prev_dir_y, dir_y);
		prev_step_x = step_x;
		prev_step_y = step_y;
		prev_dir_x  = dir_x;
		prev_dir_y  = dir_y;
	end

	task automatic offer_point(input motion_pkg::point_t pt, input int gap);
		int                delay;
		motion_pkg::move_t m;
		delay = (gap != 0) ? gap : int'(lcg_next() >> 28) % 4;
		repeat (delay) @(negedge clk);
		target       = pt;
		target_valid = 1'b1;
		while (!target_ready) begin
			saw_stall = 1'b1;
			@(negedge clk);
		end
		@(posedge clk); // Taken on this edge.
		m.dx = (motion_pkg::DELTA_BITS)'(int'($signed(pt.x)) - int'($signed(last_target.x)));
		m.dy = (motion_pkg::DELTA_BITS)'(int'($signed(pt.y)) - int'($signed(last_target.y)));
		if (m != '0)
			exp_moves.push_back(m);
		last_target = pt;
		acc_total++;
		@(negedge clk);
		target_valid = 1'b0;
	endtask

	task automatic report_counts();
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
	endtask

	initial begin : watchdog
		wait (wd_armed);
		#(wd_limit);
		$display("Timeout: the run did not finish within %0d time units", wd_limit);
		other_errors++;
		report_counts();
		$display("=== FAIL ===");
		$finish;
	end

	initial begin : driver
		int                 px;
		int                 py;
		int                 dx;
		int                 dy;
		int                 sum;
		motion_pkg::point_t model_pt;
		reset        = 1'b1;
		target       = '0;
		target_valid = 1'b0;
		$readmemh("verif/xy_motion_stimulus.txt", stim);
		num_points = (int'(stim[0]) > MAX_POINTS) ? MAX_POINTS : int'(stim[0]);
		px  = 0;
		py  = 0;
		sum = 0;
		for (int i = 0; i < num_points; i++) begin
			points[i].x = stim[1 + 3*i][motion_pkg::COORD_BITS-1:0];
			points[i].y = stim[2 + 3*i][motion_pkg::COORD_BITS-1:0];
			gaps[i]     = int'(stim[3 + 3*i][7:0]);
			dx  = int'($signed(points[i].x)) - px;
			dy  = int'($signed(points[i].y)) - py;
			sum += ((abs_int(dx) > abs_int(dy)) ? abs_int(dx) : abs_int(dy)) + 1;
			px  = $signed(points[i].x);
			py  = $signed(points[i].y);
		end
		wd_limit = sum * 2 * motion_pkg::STEP_DIV * CLK_PERIOD * 2 + 2000;
		wd_armed = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_reset_state("in_reset");
		end
		reset = 1'b0;
		@(negedge clk);
		check_reset_state("after_reset");
		for (int i = 0; i < num_points; i++)
			offer_point(points[i], gaps[i]);
		@(negedge clk);
		while (!idle) @(negedge clk);
		if (seg_open)
			close_segment();
		if (exp_moves.size() != 0) begin
			$display("Error: %0d moves were never stepped", exp_moves.size());
			other_errors++;
		end
		model_pt.x = (motion_pkg::COORD_BITS)'(model_x);
		model_pt.y = (motion_pkg::COORD_BITS)'(model_y);
		check_point("end_position", last_target, model_pt);
		check_bit("burst_stall_seen", 1'b1, saw_stall);
		report_counts();
		if (value_errors == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule : xy_motion_tb

/* xy_motion_top.f */
design/motion_pkg.sv
design/step_rate_gen.sv
design/move_fifo.sv
design/move_planner.sv
design/xy_stepper.sv
design/xy_motion_top.sv
verif/xy_motion_tb.sv
